// ==== hdl/cl_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared widths, status bus structs and constants for the scrubber shell.
// The control word bit positions are fixed, so the channel count is a
// constant here and not a module parameter.
////////////////////////////////////////////////////////////////////////////

package cl_pkg;

  // Number of scrubbed memory channels
  localparam int NUM_SCRB_CH = 4;

  // Control word fields, bits 0 to 3 enable channels 0 to 3
  localparam int CTL_DBG_EN_BIT  = 31;
  localparam int CTL_DBG_SEL_LSB = 28;
  localparam int CTL_DBG_SEL_W   = 3;

  typedef logic [63:0] scrb_addr_t;
  typedef logic [31:0] ctl_word_t;
  typedef logic [31:0] id_word_t;
  typedef logic [7:0]  stat_addr_t;
  typedef logic [31:0] stat_data_t;

  // PCI ID words shown while debug is off
  localparam id_word_t CL_SH_ID0 = 32'hF000_1D0F;
  localparam id_word_t CL_SH_ID1 = 32'h1D51_FEDC;

  // Request toward the status register file
  typedef struct packed {
    logic       wr;
    logic       rd;
    stat_addr_t addr;
    stat_data_t wdata;
  } stat_req_t;

  // Response back toward the shell
  typedef struct packed {
    logic       ack;
    stat_data_t rdata;
  } stat_rsp_t;

  typedef enum logic [1:0] {
    SCRB_IDLE,
    SCRB_RUN,
    SCRB_DONE
  } scrb_state_e;

endpackage

// ==== hdl/shell_ctl.sv ====
////////////////////////////////////////////////////////////////////////////
// Shell control word, automatic FLR acknowledge and ID word outputs.
// While FLR assert stays high, done pulses on every second cycle.
// Debug select values above the channel count show channel 0.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module shell_ctl import cl_pkg::*; (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n,
  input  logic                   i_flr_assert,
  input  ctl_word_t              i_ctl0,
  input  scrb_addr_t             i_scrb_addr [NUM_SCRB_CH],
  output logic                   o_flr_done,
  output logic [NUM_SCRB_CH-1:0] o_scrb_en,
  output id_word_t               o_id0,
  output id_word_t               o_id1
);

  ctl_word_t                ctl_q;
  logic                     flr_assert_q;
  logic                     dbg_en;
  logic [CTL_DBG_SEL_W-1:0] dbg_sel;
  scrb_addr_t               sel_addr;

  ////////////////////////////////////////////////////////////////////////////
  // FLR acknowledge

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      flr_assert_q <= 1'b0;
      o_flr_done   <= 1'b0;
    end else begin
      flr_assert_q <= i_flr_assert;
      // Single pulse, then a gap cycle before the next one
      o_flr_done   <= flr_assert_q && !o_flr_done;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Control word and ID selection

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      ctl_q <= '0;
    end else begin
      ctl_q <= i_ctl0;
    end
  end

  assign o_scrb_en = ctl_q[NUM_SCRB_CH-1:0];
  assign dbg_en    = ctl_q[CTL_DBG_EN_BIT];
  assign dbg_sel   = ctl_q[CTL_DBG_SEL_LSB +: CTL_DBG_SEL_W];

  // Channel 0 unless the select names a valid channel
  always_comb begin
    sel_addr = i_scrb_addr[0];
    for (int ch = 1; ch < NUM_SCRB_CH; ch++) begin
      if (dbg_sel == ch) begin
        sel_addr = i_scrb_addr[ch];
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      o_id0 <= CL_SH_ID0;
      o_id1 <= CL_SH_ID1;
    end else begin
      o_id0 <= dbg_en ? sel_addr[31:0]  : CL_SH_ID0;
      o_id1 <= dbg_en ? sel_addr[63:32] : CL_SH_ID1;
    end
  end

  // The shell expects isolated done pulses, never a level
  a_flr_done_pulse: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    o_flr_done |=> !o_flr_done
  );

endmodule

// ==== hdl/scrb_addr_walker.sv ====
////////////////////////////////////////////////////////////////////////////
// Burst address walker for one memory channel, one burst per cycle.
// No memory writes are issued. SCRB_MAX_ADDR+1 must fit in 64 bits.
// Dropping the enable restarts the walk from address 0.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module scrb_addr_walker import cl_pkg::*; #(
  parameter scrb_addr_t  SCRB_MAX_ADDR    = 64'h1FFF,
  parameter int unsigned SCRB_BURST_BYTES = 1024
) (
  input  logic       clk_main_a0,
  input  logic       rst_main_n,
  input  logic       i_enable,
  output scrb_addr_t o_addr,
  output logic       o_done
);

  // Address held once the walk is complete
  localparam scrb_addr_t END_ADDR = SCRB_MAX_ADDR + 64'd1;

  scrb_state_e state_q;
  scrb_addr_t  addr_q;
  scrb_addr_t  next_addr;

  assign next_addr = addr_q + scrb_addr_t'(SCRB_BURST_BYTES);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n || !i_enable) begin
      state_q <= SCRB_IDLE;
      addr_q  <= '0;
    end else begin
      case (state_q)
        SCRB_IDLE: begin
          state_q <= SCRB_RUN;
          addr_q  <= '0;
        end
        SCRB_RUN: begin
          // Last burst already issued
          if (next_addr > SCRB_MAX_ADDR) begin
            state_q <= SCRB_DONE;
            addr_q  <= END_ADDR;
          end else begin
            addr_q  <= next_addr;
          end
        end
        SCRB_DONE: state_q <= SCRB_DONE;
        default:   state_q <= SCRB_IDLE;
      endcase
    end
  end

  assign o_addr = addr_q;
  assign o_done = (state_q == SCRB_DONE);

  a_done_addr: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    o_done |-> (o_addr == END_ADDR)
  );

endmodule

// ==== hdl/stat_pipe.sv ====
////////////////////////////////////////////////////////////////////////////
// Fixed-depth register pipeline for one direction of the status bus.
// Latency is STAGES cycles, STAGES must be at least 1.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module stat_pipe #(
  parameter int WIDTH  = 42,
  parameter int STAGES = 8
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n,
  input  logic [WIDTH-1:0] i_bus,
  output logic [WIDTH-1:0] o_bus
);

  logic [WIDTH-1:0] pipe_q [STAGES];

  // Strobes ride in the bus, so every stage resets
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      for (int s = 0; s < STAGES; s++) begin
        pipe_q[s] <= '0;
      end
    end else begin
      pipe_q[0] <= i_bus;
      for (int s = 1; s < STAGES; s++) begin
        pipe_q[s] <= pipe_q[s-1];
      end
    end
  end

  assign o_bus = pipe_q[STAGES-1];

endmodule

// ==== hdl/ddr_stat_regs.sv ====
////////////////////////////////////////////////////////////////////////////
// Status register file standing in for the DDR controller status target.
// 16 registers, only the low 4 address bits decode, upper ones alias.
// Ack follows each strobe by one cycle, a write echoes its data.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module ddr_stat_regs import cl_pkg::*; (
  input  logic      clk_main_a0,
  input  logic      rst_main_n,
  input  stat_req_t i_req,
  output stat_rsp_t o_rsp
);

  stat_data_t regs_q [16];
  logic       ack_q;
  stat_data_t rdata_q;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      for (int r = 0; r < 16; r++) begin
        regs_q[r] <= '0;
      end
    end else if (i_req.wr) begin
      regs_q[i_req.addr[3:0]] <= i_req.wdata;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= i_req.wr || i_req.rd;
    end
  end

  // Read data only matters alongside ack
  always_ff @(posedge clk_main_a0) begin
    rdata_q <= i_req.wr ? i_req.wdata : regs_q[i_req.addr[3:0]];
  end

  assign o_rsp = '{ack: ack_q, rdata: rdata_q};

  a_one_strobe: assert property (
    @(posedge clk_main_a0) disable iff (!rst_main_n)
    !(i_req.wr && i_req.rd)
  );

endmodule

// ==== hdl/cl_scrb_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Top level: shell control, four scrub address walkers and the status
// path. Status ack comes 2*STAT_STAGES+1 cycles after each strobe and
// there is no back-pressure. All blocks share rst_main_n.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module cl_scrb_top import cl_pkg::*; #(
  parameter scrb_addr_t  SCRB_MAX_ADDR    = 64'h1FFF,
  parameter int unsigned SCRB_BURST_BYTES = 1024,
  parameter int          STAT_STAGES      = 8
) (
  input  logic                   clk_main_a0,
  input  logic                   rst_main_n,
  input  logic                   i_sh_cl_flr_assert,
  output logic                   o_cl_sh_flr_done,
  input  ctl_word_t              i_sh_cl_ctl0,
  output id_word_t               o_cl_sh_id0,
  output id_word_t               o_cl_sh_id1,
  output logic [NUM_SCRB_CH-1:0] o_scrb_done,
  input  logic                   i_stat_wr,
  input  logic                   i_stat_rd,
  input  stat_addr_t             i_stat_addr,
  input  stat_data_t             i_stat_wdata,
  output logic                   o_stat_ack,
  output stat_data_t             o_stat_rdata
);

  logic [NUM_SCRB_CH-1:0] scrb_en;
  scrb_addr_t             scrb_addr [NUM_SCRB_CH];
  stat_req_t              stat_req;
  stat_req_t              stat_req_q;
  stat_rsp_t              stat_rsp;
  stat_rsp_t              stat_rsp_q;

  shell_ctl shell_ctl_i (
    .clk_main_a0  (clk_main_a0),
    .rst_main_n   (rst_main_n),
    .i_flr_assert (i_sh_cl_flr_assert),
    .i_ctl0       (i_sh_cl_ctl0),
    .i_scrb_addr  (scrb_addr),
    .o_flr_done   (o_cl_sh_flr_done),
    .o_scrb_en    (scrb_en),
    .o_id0        (o_cl_sh_id0),
    .o_id1        (o_cl_sh_id1)
  );

  // One walker per channel, enable bit n drives channel n
  for (genvar ch = 0; ch < NUM_SCRB_CH; ch++) begin : g_scrb
    scrb_addr_walker #(
      .SCRB_MAX_ADDR    (SCRB_MAX_ADDR),
      .SCRB_BURST_BYTES (SCRB_BURST_BYTES)
    ) walker_i (
      .clk_main_a0 (clk_main_a0),
      .rst_main_n  (rst_main_n),
      .i_enable    (scrb_en[ch]),
      .o_addr      (scrb_addr[ch]),
      .o_done      (o_scrb_done[ch])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Status bus, pipelined both ways around the register file

  assign stat_req = '{wr: i_stat_wr, rd: i_stat_rd, addr: i_stat_addr, wdata: i_stat_wdata};

  stat_pipe #(
    .WIDTH  ($bits(stat_req_t)),
    .STAGES (STAT_STAGES)
  ) req_pipe_i (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .i_bus       (stat_req),
    .o_bus       (stat_req_q)
  );

  ddr_stat_regs stat_regs_i (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .i_req       (stat_req_q),
    .o_rsp       (stat_rsp)
  );

  stat_pipe #(
    .WIDTH  ($bits(stat_rsp_t)),
    .STAGES (STAT_STAGES)
  ) rsp_pipe_i (
    .clk_main_a0 (clk_main_a0),
    .rst_main_n  (rst_main_n),
    .i_bus       (stat_rsp),
    .o_bus       (stat_rsp_q)
  );

  assign o_stat_ack   = stat_rsp_q.ack;
  assign o_stat_rdata = stat_rsp_q.rdata;

endmodule

// ==== dv/tb_cl_scrb_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Self-checking testbench for cl_scrb_top, replays dv/tb_vectors.txt.
// Must run from the project root so the vector path resolves.
// Status data comes from $random, a register model predicts read data.
// Ack latency is checked against 2*STAT_STAGES+1 for every strobe.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_cl_scrb_top import cl_pkg::*;;

  localparam int STAT_STAGES  = 8;
  localparam int ACK_LATENCY  = 2 * STAT_STAGES + 1;
  localparam int DONE_TIMEOUT = 50;
  localparam int ACK_TIMEOUT  = 100;
  localparam int VEC_WORDS    = 128;

  logic                   clk_main_a0;
  logic                   rst_main_n;
  logic                   i_sh_cl_flr_assert;
  logic                   o_cl_sh_flr_done;
  ctl_word_t              i_sh_cl_ctl0;
  id_word_t               o_cl_sh_id0;
  id_word_t               o_cl_sh_id1;
  logic [NUM_SCRB_CH-1:0] o_scrb_done;
  logic                   i_stat_wr;
  logic                   i_stat_rd;
  stat_addr_t             i_stat_addr;
  stat_data_t             i_stat_wdata;
  logic                   o_stat_ack;
  stat_data_t             o_stat_rdata;

  integer      seed;
  int          err_count;
  int          timeout_count;
  int unsigned cyc_count;
  logic [31:0] vec_mem [VEC_WORDS];
  stat_data_t  reg_model [16];
  stat_addr_t  written_addr [$];
  stat_data_t  exp_rdata [$];
  int unsigned strobe_cyc [$];

  cl_scrb_top #(
    .SCRB_MAX_ADDR    (64'h1FFF),
    .SCRB_BURST_BYTES (1024),
    .STAT_STAGES      (STAT_STAGES)
  ) dut_i (
    .clk_main_a0        (clk_main_a0),
    .rst_main_n         (rst_main_n),
    .i_sh_cl_flr_assert (i_sh_cl_flr_assert),
    .o_cl_sh_flr_done   (o_cl_sh_flr_done),
    .i_sh_cl_ctl0       (i_sh_cl_ctl0),
    .o_cl_sh_id0        (o_cl_sh_id0),
    .o_cl_sh_id1        (o_cl_sh_id1),
    .o_scrb_done        (o_scrb_done),
    .i_stat_wr          (i_stat_wr),
    .i_stat_rd          (i_stat_rd),
    .i_stat_addr        (i_stat_addr),
    .i_stat_wdata       (i_stat_wdata),
    .o_stat_ack         (o_stat_ack),
    .o_stat_rdata       (o_stat_rdata)
  );

  initial begin
    clk_main_a0 = 1'b0;
    forever #5 clk_main_a0 = ~clk_main_a0;
  end

  always @(posedge clk_main_a0) begin
    cyc_count <= cyc_count + 1;
  end

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      err_count++;
      $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
               $time, what, actual, expected);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Status ack monitor, matches each ack to the oldest strobe

  always @(negedge clk_main_a0) begin : ack_monitor
    int unsigned sent_cyc;
    if (rst_main_n) begin
      if (i_stat_wr || i_stat_rd) begin
        strobe_cyc.push_back(cyc_count);
      end
      if (o_stat_ack) begin
        if (strobe_cyc.size() == 0 || exp_rdata.size() == 0) begin
          err_count++;
          $display("Status ack at %0t with no request outstanding", $time);
        end else begin
          sent_cyc = strobe_cyc.pop_front();
          check_value(64'(cyc_count - sent_cyc), 64'(ACK_LATENCY), "status ack latency");
          check_value(64'(o_stat_rdata), 64'(exp_rdata.pop_front()), "status read data");
        end
      end
    end
  end

  // Holds FLR assert and checks done on every cycle
  task automatic check_flr(input int cycles);
    int j;
    logic expect_done;
    @(posedge clk_main_a0);
    i_sh_cl_flr_assert <= 1'b1;
    for (j = 1; j <= cycles; j++) begin
      @(negedge clk_main_a0);
      expect_done = (j >= 3) && (j % 2 == 1);
      check_value(64'(o_cl_sh_flr_done), 64'(expect_done), "FLR done pulse");
    end
    @(posedge clk_main_a0);
    i_sh_cl_flr_assert <= 1'b0;
  endtask

  task automatic wait_for_done(input logic [NUM_SCRB_CH-1:0] expected);
    int waited;
    waited = 0;
    @(negedge clk_main_a0);
    while (o_scrb_done !== expected && waited < DONE_TIMEOUT) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (o_scrb_done !== expected) begin
      timeout_count++;
      $display("Timeout at %0t: done flags stayed at %b while waiting for %b",
               $time, o_scrb_done, expected);
    end
  endtask

  // Back to back writes to random addresses
  task automatic issue_writes(input int count);
    int n;
    stat_addr_t addr;
    stat_data_t data;
    for (n = 0; n < count; n++) begin
      addr = stat_addr_t'($random(seed));
      data = $random(seed);
      @(posedge clk_main_a0);
      i_stat_wr    <= 1'b1;
      i_stat_addr  <= addr;
      i_stat_wdata <= data;
      reg_model[addr[3:0]] = data;
      written_addr.push_back(addr);
      exp_rdata.push_back(data);
    end
    @(posedge clk_main_a0);
    i_stat_wr <= 1'b0;
  endtask

  // Reads back the written addresses, write data is junk on purpose
  task automatic issue_reads(input int count);
    int n;
    stat_addr_t addr;
    for (n = 0; n < count && written_addr.size() > 0; n++) begin
      addr = written_addr.pop_front();
      @(posedge clk_main_a0);
      i_stat_rd    <= 1'b1;
      i_stat_addr  <= addr;
      i_stat_wdata <= $random(seed);
      exp_rdata.push_back(reg_model[addr[3:0]]);
    end
    @(posedge clk_main_a0);
    i_stat_rd <= 1'b0;
  endtask

  task automatic drain_acks();
    int waited;
    waited = 0;
    while (exp_rdata.size() > 0 && waited < ACK_TIMEOUT) begin
      @(negedge clk_main_a0);
      waited++;
    end
    if (exp_rdata.size() > 0) begin
      timeout_count++;
      $display("Timeout at %0t: %0d status acks never arrived", $time, exp_rdata.size());
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Vector replay

  initial begin
    int fd;
    int pc;
    logic running;
    logic [31:0] op;
    logic [31:0] arg;
    seed               = 32'h1fa0_b0d7;
    err_count          = 0;
    timeout_count      = 0;
    cyc_count          = 0;
    running            = 1'b1;
    rst_main_n         = 1'b0;
    i_sh_cl_flr_assert = 1'b0;
    i_sh_cl_ctl0       = '0;
    i_stat_wr          = 1'b0;
    i_stat_rd          = 1'b0;
    i_stat_addr        = '0;
    i_stat_wdata       = '0;
    for (pc = 0; pc < 16; pc++) begin
      reg_model[pc] = '0;
    end
    for (pc = 0; pc < VEC_WORDS; pc++) begin
      vec_mem[pc] = '0;
    end
    fd = $fopen("dv/tb_vectors.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("Could not open the vector file dv/tb_vectors.txt");
    end else begin
      $fclose(fd);
      $readmemh("dv/tb_vectors.txt", vec_mem);
    end

    repeat (5) @(posedge clk_main_a0);
    rst_main_n <= 1'b1;
    @(negedge clk_main_a0);
    check_value(64'(o_cl_sh_flr_done), 64'd0, "FLR done after reset");
    check_value(64'(o_stat_ack), 64'd0, "status ack after reset");

    for (pc = 0; pc < VEC_WORDS / 2 && running; pc++) begin
      op  = vec_mem[2*pc];
      arg = vec_mem[2*pc+1];
      case (op)
        32'h0: running = 1'b0;
        32'h1: begin
          @(posedge clk_main_a0);
          i_sh_cl_ctl0 <= arg;
        end
        32'h2: repeat (arg) @(posedge clk_main_a0);
        32'h3: begin
          @(negedge clk_main_a0);
          check_value(64'(o_cl_sh_id0), 64'(arg), "id0");
        end
        32'h4: begin
          @(negedge clk_main_a0);
          check_value(64'(o_cl_sh_id1), 64'(arg), "id1");
        end
        32'h5: begin
          @(negedge clk_main_a0);
          check_value(64'(o_scrb_done), 64'(arg[NUM_SCRB_CH-1:0]), "done flags");
        end
        32'h6: check_flr(int'(arg));
        32'h7: wait_for_done(arg[NUM_SCRB_CH-1:0]);
        32'h8: issue_writes(int'(arg));
        32'h9: issue_reads(int'(arg));
        32'hA: drain_acks();
        default: begin
          err_count++;
          $display("Unknown vector operation %0h at entry %0d", op, pc);
          running = 1'b0;
        end
      endcase
    end
    drain_acks();

    $display("Run complete: %0d errors, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== dv/tb_vectors.txt ====
// Columns: op, argument (hex). 1 ctl word, 2 wait cycles, 3 id0, 4 id1, 5 done flags,
// 6 FLR cycles, 7 wait for done, 8 writes, 9 reads, A drain acks, 0 end
3 F0001D0F
4 1D51FEDC
5 00000000
6 00000009
2 00000004
1 00000005
7 00000005
1 A0000005
2 00000002
3 00002000
4 00000000
1 90000005
2 00000002
3 00000000
4 00000000
1 80000001
7 00000001
1 00000001
2 00000002
3 F0001D0F
4 1D51FEDC
8 00000006
9 00000006
A 00000000
0 00000000

// ==== project.f ====
hdl/cl_pkg.sv
hdl/shell_ctl.sv
hdl/scrb_addr_walker.sv
hdl/stat_pipe.sv
hdl/ddr_stat_regs.sv
hdl/cl_scrb_top.sv
dv/tb_cl_scrb_top.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cl_scrb_top -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_cl_scrb_top)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
